// ==== include/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath widths
`define EX_DATA_W        32
`define EX_REG_AW        5

// opcode and funct packed side by side
`define EX_ALU_OPC_WIDTH 12

`define EX_APB_AW        12

// register map, GPR window is 0x000..0x07C
`define EX_ADDR_GPR_LAST 12'h07C
`define EX_ADDR_INSTR    12'h080
`define EX_ADDR_RESULT   12'h084

`endif

// ==== hdl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI,
    OP_PASS_A
  } op_t;

  typedef enum logic {
    RES_ALU,
    RES_SET
  } res_unit_t;

  // major opcode field, instr[31:26]
  typedef enum logic [5:0] {
    OPC_SPECIAL = 6'h00,
    OPC_ADDI    = 6'h08,
    OPC_ADDIU   = 6'h09,
    OPC_SLTI    = 6'h0a,
    OPC_SLTIU   = 6'h0b,
    OPC_ANDI    = 6'h0c,
    OPC_ORI     = 6'h0d,
    OPC_XORI    = 6'h0e,
    OPC_LUI     = 6'h0f
  } opc_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'd0,
    FN_SRL  = 6'd2,
    FN_SRA  = 6'd3,
    FN_SLLV = 6'd4,
    FN_SRLV = 6'd6,
    FN_SRAV = 6'd7,
    FN_ADD  = 6'd32,
    FN_ADDU = 6'd33,
    FN_SUB  = 6'd34,
    FN_SUBU = 6'd35,
    FN_AND  = 6'd36,
    FN_OR   = 6'd37,
    FN_XOR  = 6'd38,
    FN_NOR  = 6'd39,
    FN_SLT  = 6'd42,
    FN_SLTU = 6'd43
  } funct_t;

endpackage

`default_nettype wire

// ==== hdl/alu_decode.sv ====
`default_nettype none

`include "ex_defs.svh"

module alu_decode (
  input  wire logic [`EX_DATA_W-1:0] instr,
  output ex_pkg::op_t                op,
  output ex_pkg::res_unit_t          res_unit,
  output logic                       set_unsigned,
  output logic                       shift_var,
  output logic                       use_imm,
  output logic                       imm_zero_ext,
  output logic [`EX_REG_AW-1:0]      dest_reg,
  output logic                       dest_valid
);
  import ex_pkg::*;

  logic [`EX_ALU_OPC_WIDTH-1:0] opc_funct;
  opc_t                         opc;
  funct_t                       funct;
  logic                         known;
  logic                         write_rd;

  assign opc_funct = {instr[31:26], instr[5:0]};
  assign opc       = opc_t'(opc_funct[11:6]);
  assign funct     = funct_t'(opc_funct[5:0]);

  always_comb begin
    op           = OP_PASS_A;
    res_unit     = RES_ALU;
    set_unsigned = 1'b0;
    shift_var    = 1'b0;
    use_imm      = 1'b1;
    imm_zero_ext = 1'b0;
    write_rd     = 1'b0;
    known        = 1'b1;

    case (opc)
      OPC_SPECIAL: begin
        use_imm  = 1'b0;
        write_rd = 1'b1;
        case (funct)
          FN_SLL:          op = OP_SLL;
          FN_SRL:          op = OP_SRL;
          FN_SRA:          op = OP_SRA;
          FN_SLLV: begin
            op        = OP_SLL;
            shift_var = 1'b1;
          end
          FN_SRLV: begin
            op        = OP_SRL;
            shift_var = 1'b1;
          end
          FN_SRAV: begin
            op        = OP_SRA;
            shift_var = 1'b1;
          end
          FN_ADD, FN_ADDU: op = OP_ADD; // no overflow trap
          FN_SUB, FN_SUBU: op = OP_SUB;
          FN_AND:          op = OP_AND;
          FN_OR:           op = OP_OR;
          FN_XOR:          op = OP_XOR;
          FN_NOR:          op = OP_NOR;
          FN_SLT: begin
            op       = OP_SUB;
            res_unit = RES_SET;
          end
          FN_SLTU: begin
            op           = OP_SUB;
            res_unit     = RES_SET;
            set_unsigned = 1'b1;
          end
          default:         known = 1'b0;
        endcase
      end
      OPC_ADDI, OPC_ADDIU: op = OP_ADD;
      OPC_SLTI: begin
        op       = OP_SUB;
        res_unit = RES_SET;
      end
      OPC_SLTIU: begin
        op           = OP_SUB;
        res_unit     = RES_SET;
        set_unsigned = 1'b1; // imm still sign extended
      end
      OPC_ANDI: begin
        op           = OP_AND;
        imm_zero_ext = 1'b1;
      end
      OPC_ORI: begin
        op           = OP_OR;
        imm_zero_ext = 1'b1;
      end
      OPC_XORI: begin
        op           = OP_XOR;
        imm_zero_ext = 1'b1;
      end
      OPC_LUI:             op = OP_LUI;
      default:             known = 1'b0;
    endcase
  end

  assign dest_reg   = write_rd ? instr[15:11] : instr[20:16]; // rd vs rt
  assign dest_valid = known;

  always_comb begin
    assert (!(dest_valid && op == OP_PASS_A))
      else $error("decode: pass_a marked as a writing instruction");
  end

endmodule

`default_nettype wire

// ==== hdl/barrel_shifter.sv ====
`default_nettype none

`include "ex_defs.svh"

module barrel_shifter (
  input  wire logic [`EX_DATA_W-1:0] value,
  input  wire logic [`EX_REG_AW-1:0] amount,
  input  wire ex_pkg::op_t           op,
  output logic [`EX_DATA_W-1:0]      shifted
);
  import ex_pkg::*;

  localparam int W = `EX_DATA_W;
  localparam int N = `EX_REG_AW;

  logic [N:0][W-1:0] stage;
  logic              fill;
  logic              left;

  assign fill     = (op == OP_SRA) ? value[W-1] : 1'b0; // sign fill for sra only
  assign left     = (op == OP_SLL);
  assign stage[0] = value;

  // stage i shifts by 2**i when amount[i] is set
  for (genvar i = 0; i < N; i++) begin : g_stage
    localparam int S = 1 << i;

    logic [W-1:0] to_left;
    logic [W-1:0] to_right;

    assign to_left  = {stage[i][W-S-1:0], {S{1'b0}}};
    assign to_right = {{S{fill}}, stage[i][W-1:S]};

    assign stage[i+1] = !amount[i] ? stage[i] :
                        left       ? to_left  :
                                     to_right;
  end

  assign shifted = stage[N];

endmodule

`default_nettype wire

// ==== hdl/ex.sv ====
`default_nettype none

`include "ex_defs.svh"

module ex (
  input  wire logic [`EX_DATA_W-1:0] instr,
  input  wire logic [`EX_DATA_W-1:0] rs_val,
  input  wire logic [`EX_DATA_W-1:0] rt_val,
  output logic [`EX_DATA_W-1:0]      result,
  output logic [`EX_REG_AW-1:0]      dest_reg,
  output logic                       dest_valid
);
  import ex_pkg::*;

  localparam int W = `EX_DATA_W;

  op_t                 op;
  res_unit_t           res_unit;
  logic                set_unsigned;
  logic                shift_var;
  logic                use_imm;
  logic                imm_zero_ext;
  logic [W-1:0]        imm_ext;
  logic [W-1:0]        a;
  logic [W-1:0]        b;
  logic [W-1:0]        sum;
  logic [W-1:0]        diff;
  logic                sub_carry;
  logic                sub_ovf;
  logic                set_bit;
  logic [W-1:0]        set_res;
  logic [W-1:0]        alu_res;
  logic [`EX_REG_AW-1:0] shift_amt;
  logic [W-1:0]        shifted;

  alu_decode alu_decode_i (
    .instr        (instr),
    .op           (op),
    .res_unit     (res_unit),
    .set_unsigned (set_unsigned),
    .shift_var    (shift_var),
    .use_imm      (use_imm),
    .imm_zero_ext (imm_zero_ext),
    .dest_reg     (dest_reg),
    .dest_valid   (dest_valid)
  );

  assign imm_ext = imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  assign a       = rs_val;
  assign b       = use_imm ? imm_ext : rt_val;

  assign shift_amt = shift_var ? rs_val[`EX_REG_AW-1:0] : instr[10:6]; // sllv etc use rs

  barrel_shifter barrel_shifter_i (
    .value   (rt_val),
    .amount  (shift_amt),
    .op      (op),
    .shifted (shifted)
  );

  assign sum                = a + b;
  assign {sub_carry, diff}  = {1'b0, a} + {1'b0, ~b} + {{W{1'b0}}, 1'b1}; // carry = no borrow

  always_comb begin
    case (op)
      OP_ADD:                alu_res = sum;
      OP_SUB:                alu_res = diff;
      OP_OR:                 alu_res = a | b;
      OP_XOR:                alu_res = a ^ b;
      OP_NOR:                alu_res = ~(a | b);
      OP_AND:                alu_res = a & b;
      OP_SLL, OP_SRL, OP_SRA: alu_res = shifted;
      OP_LUI:                alu_res = {b[15:0], 16'b0};
      default:               alu_res = a; // pass_a
    endcase
  end

  // slt corrects the sign of the difference on overflow
  assign sub_ovf = (a[W-1] ^ b[W-1]) & (diff[W-1] ^ a[W-1]);
  assign set_bit = set_unsigned ? ~sub_carry : (diff[W-1] ^ sub_ovf);
  assign set_res = {{(W-1){1'b0}}, set_bit};

  assign result = (res_unit == RES_SET) ? set_res : alu_res;

endmodule

`default_nettype wire

// ==== hdl/gpr_file.sv ====
`default_nettype none

`include "ex_defs.svh"

module gpr_file (
  input  wire logic                  clock,
  input  wire logic                  rst_n,
  input  wire logic                  we,
  input  wire logic [`EX_REG_AW-1:0] waddr,
  input  wire logic [`EX_DATA_W-1:0] wdata,
  input  wire logic [`EX_REG_AW-1:0] raddr_a,
  output logic [`EX_DATA_W-1:0]      rdata_a,
  input  wire logic [`EX_REG_AW-1:0] raddr_b,
  output logic [`EX_DATA_W-1:0]      rdata_b,
  input  wire logic [`EX_REG_AW-1:0] raddr_c,
  output logic [`EX_DATA_W-1:0]      rdata_c
);

  localparam int NREG = 1 << `EX_REG_AW;

  // r1..r31 only, r0 has no storage
  logic [NREG-1:1][`EX_DATA_W-1:0] regs;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '0;
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];
  assign rdata_c = (raddr_c == '0) ? '0 : regs[raddr_c];

  a_r0_write_no_effect: assert property (
    @(posedge clock) disable iff (!rst_n)
    (we && waddr == '0) |=> $stable(regs)
  ) else $error("gpr_file: write to r0 changed stored state");

endmodule

`default_nettype wire

// ==== hdl/ex_apb_top.sv ====
`default_nettype none

`include "ex_defs.svh"

module ex_apb_top (
  input  wire logic                  clock,
  input  wire logic                  rst_n,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire logic [`EX_APB_AW-1:0] paddr,
  input  wire logic [`EX_DATA_W-1:0] pwdata,
  output logic [`EX_DATA_W-1:0]      prdata,
  output logic                       pready,
  output logic                       pslverr
);

  logic                  access;
  logic                  gpr_hit;
  logic                  instr_hit;
  logic                  result_hit;
  logic                  write_ok;
  logic                  read_ok;
  logic                  apb_gpr_we;
  logic                  instr_we;
  logic                  exec_pending;
  logic [`EX_DATA_W-1:0] instr_reg;
  logic [`EX_DATA_W-1:0] result_reg;
  logic [`EX_REG_AW-1:0] apb_idx;

  logic                  gpr_we;
  logic [`EX_REG_AW-1:0] gpr_waddr;
  logic [`EX_DATA_W-1:0] gpr_wdata;
  logic [`EX_DATA_W-1:0] rs_val;
  logic [`EX_DATA_W-1:0] rt_val;
  logic [`EX_DATA_W-1:0] apb_rdata;

  logic [`EX_DATA_W-1:0] ex_result;
  logic [`EX_REG_AW-1:0] ex_dest_reg;
  logic                  ex_dest_valid;

  assign access     = psel & penable;
  assign gpr_hit    = (paddr <= `EX_ADDR_GPR_LAST) && (paddr[1:0] == 2'b00);
  assign instr_hit  = (paddr == `EX_ADDR_INSTR);
  assign result_hit = (paddr == `EX_ADDR_RESULT);
  assign apb_idx    = paddr[`EX_REG_AW+1:2]; // word index in the GPR window

  assign write_ok = gpr_hit | instr_hit; // RESULT is read only
  assign read_ok  = gpr_hit | instr_hit | result_hit;

  assign apb_gpr_we = access & pwrite & gpr_hit;
  assign instr_we   = access & pwrite & instr_hit;

  assign pready  = 1'b1;
  assign pslverr = access & (pwrite ? ~write_ok : ~read_ok);

  always_comb begin
    if (gpr_hit) begin
      prdata = apb_rdata;
    end else if (instr_hit) begin
      prdata = instr_reg;
    end else if (result_hit) begin
      prdata = result_reg;
    end else begin
      prdata = '0;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      instr_reg    <= '0;
      exec_pending <= 1'b0;
      result_reg   <= '0;
    end else begin
      exec_pending <= instr_we; // one cycle only
      if (instr_we) begin
        instr_reg <= pwdata;
      end
      if (exec_pending) begin
        result_reg <= ex_result;
      end
    end
  end

  // single write port, write-back owns it during exec_pending
  assign gpr_we    = exec_pending ? ex_dest_valid : apb_gpr_we;
  assign gpr_waddr = exec_pending ? ex_dest_reg : apb_idx;
  assign gpr_wdata = exec_pending ? ex_result : pwdata;

  gpr_file gpr_file_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .we      (gpr_we),
    .waddr   (gpr_waddr),
    .wdata   (gpr_wdata),
    .raddr_a (instr_reg[25:21]), // rs
    .rdata_a (rs_val),
    .raddr_b (instr_reg[20:16]), // rt
    .rdata_b (rt_val),
    .raddr_c (apb_idx),
    .rdata_c (apb_rdata)
  );

  ex ex_i (
    .instr      (instr_reg),
    .rs_val     (rs_val),
    .rt_val     (rt_val),
    .result     (ex_result),
    .dest_reg   (ex_dest_reg),
    .dest_valid (ex_dest_valid)
  );

  // the setup phase of the next transfer covers the write-back cycle
  a_no_wb_collision: assert property (
    @(posedge clock) disable iff (!rst_n)
    !(apb_gpr_we && exec_pending)
  ) else $error("ex_apb_top: APB GPR write during write-back");

endmodule

`default_nettype wire

// ==== dv/ex_apb_top_tb.sv ====
`default_nettype none

`include "ex_defs.svh"

module ex_apb_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs_v;
    logic [31:0] rt_v;
    logic [31:0] exp_res;
    logic [4:0]  dreg;
    logic [31:0] exp_d;
  } row_t;

  localparam logic [31:0] SENTINEL = 32'hdead_beef;
  localparam int NROWS  = 29;
  localparam int NRAND  = 32;
  localparam int LIMIT  = NROWS * 12 + NRAND * 12 + 16;

  // operands always sit in r1 (rs) and r2 (rt)
  function automatic logic [31:0] rtype(input logic [4:0] rd, input logic [4:0] sh,
                                        input logic [5:0] fn);
    return {6'h00, 5'd1, 5'd2, rd, sh, fn};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] opc, input logic [15:0] imm);
    return {opc, 5'd1, 5'd4, imm}; // rt = r4 is the destination
  endfunction

  localparam row_t ROWS [NROWS] = '{
    '{rtype(3, 0, 32), 32'h5, 32'h7, 32'hc, 5'd3, 32'hc},
    '{rtype(3, 0, 34), 32'h5, 32'h7, 32'hffff_fffe, 5'd3, 32'hffff_fffe},
    '{rtype(3, 0, 36), 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 5'd3, 32'h00f0_1200},
    '{rtype(3, 0, 37), 32'hf0f0_1234, 32'h0ff0_ff00, 32'hfff0_ff34, 5'd3, 32'hfff0_ff34},
    '{rtype(3, 0, 38), 32'hf0f0_1234, 32'h0ff0_ff00, 32'hff00_ed34, 5'd3, 32'hff00_ed34},
    '{rtype(3, 0, 39), 32'hf0f0_1234, 32'h0ff0_ff00, 32'h000f_00cb, 5'd3, 32'h000f_00cb},
    '{rtype(3, 0, 42), 32'hffff_ffff, 32'h1, 32'h1, 5'd3, 32'h1},
    '{rtype(3, 0, 42), 32'h7fff_ffff, 32'h8000_0000, 32'h0, 5'd3, 32'h0},
    '{rtype(3, 0, 43), 32'hffff_ffff, 32'h1, 32'h0, 5'd3, 32'h0},
    '{rtype(3, 0, 43), 32'h7fff_ffff, 32'h8000_0000, 32'h1, 5'd3, 32'h1},
    '{rtype(3, 4, 0), 32'h0, 32'h1, 32'h10, 5'd3, 32'h10},
    '{rtype(3, 31, 0), 32'h0, 32'h3, 32'h8000_0000, 5'd3, 32'h8000_0000},
    '{rtype(3, 0, 2), 32'h0, 32'h8000_0000, 32'h8000_0000, 5'd3, 32'h8000_0000},
    '{rtype(3, 4, 3), 32'h0, 32'h8000_0000, 32'hf800_0000, 5'd3, 32'hf800_0000},
    '{rtype(3, 31, 3), 32'h0, 32'h8000_0000, 32'hffff_ffff, 5'd3, 32'hffff_ffff},
    '{rtype(3, 0, 4), 32'h23, 32'h1, 32'h8, 5'd3, 32'h8},
    '{rtype(3, 0, 6), 32'h1f, 32'h8000_0000, 32'h1, 5'd3, 32'h1},
    '{rtype(3, 0, 7), 32'h4, 32'hf000_0000, 32'hff00_0000, 5'd3, 32'hff00_0000},
    '{itype(6'h08, 16'hffff), 32'h5, 32'h0, 32'h4, 5'd4, 32'h4},
    '{itype(6'h0a, 16'hffff), 32'hffff_fffe, 32'h0, 32'h1, 5'd4, 32'h1},
    '{itype(6'h0b, 16'hffff), 32'h5, 32'h0, 32'h1, 5'd4, 32'h1},
    '{itype(6'h0c, 16'hffff), 32'h1234_5678, 32'h0, 32'h5678, 5'd4, 32'h5678},
    '{itype(6'h0d, 16'h8000), 32'h0, 32'h0, 32'h8000, 5'd4, 32'h8000},
    '{itype(6'h0e, 16'hffff), 32'hffff_ffff, 32'h0, 32'hffff_0000, 5'd4, 32'hffff_0000},
    '{itype(6'h0f, 16'h1234), 32'h0, 32'h0, 32'h1234_0000, 5'd4, 32'h1234_0000},
    '{itype(6'h09, 16'h8000), 32'h0, 32'h0, 32'hffff_8000, 5'd4, 32'hffff_8000},
    '{rtype(0, 0, 32), 32'h1, 32'h2, 32'h3, 5'd0, 32'h0}, // rd = r0
    '{rtype(3, 0, 1), 32'habcd_0123, 32'h0, 32'habcd_0123, 5'd3, SENTINEL},
    '{{6'h3f, 5'd1, 5'd4, 16'h0}, 32'h55, 32'h0, 32'h55, 5'd4, SENTINEL}
  };

  logic        clock;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          errors;
  int          cycles = 0;
  logic [31:0] lfsr;

  ex_apb_top ex_apb_top_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]}; // one step per bit
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    assert (got === exp)
      else begin
        errors++;
        $display("Mismatch pslverr on %s: got %h expected %h", what, got, exp);
      end
  endtask

  // setup on one falling edge, access on the next, sampled mid access
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wd,
                          output logic [31:0] rd, output logic err);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wd;
    @(negedge clock);
    penable = 1'b1;
    #10;
    rd  = prdata;
    err = pslverr;
    check_eq("pready", {31'd0, pready}, 32'h1);
  endtask

  task automatic apb_idle();
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] wd, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, wd, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] rd, output logic err);
    apb_xfer(1'b0, addr, '0, rd, err);
  endtask

  task automatic run_instr(input logic [31:0] instr, input logic [31:0] rs_v,
                           input logic [31:0] rt_v, output logic [31:0] res);
    logic err;
    apb_write(12'h004, rs_v, err);
    apb_write(12'h008, rt_v, err);
    apb_write(`EX_ADDR_INSTR, instr, err);
    apb_read(`EX_ADDR_RESULT, res, err);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] got;
    logic [31:0] instr;
    logic [31:0] exp;
    logic        err;

    clock   = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    errors  = 0;
    lfsr    = 32'hf79c1b60;
    repeat (16) @(negedge clock);
    rst_n = 1'b1;

    for (int i = 0; i < NROWS; i++) begin
      apb_write(12'h004, ROWS[i].rs_v, err);
      apb_write(12'h008, ROWS[i].rt_v, err);
      apb_write({5'd0, ROWS[i].dreg, 2'b00}, SENTINEL, err);
      apb_write(`EX_ADDR_INSTR, ROWS[i].instr, err);
      apb_read(`EX_ADDR_RESULT, got, err);
      check_eq("result", got, ROWS[i].exp_res);
      apb_read({5'd0, ROWS[i].dreg, 2'b00}, got, err);
      check_eq($sformatf("r%0d", ROWS[i].dreg), got, ROWS[i].exp_d);
    end

    // set-less-than on random pairs, cycling slt, sltu, slti, sltiu
    for (int i = 0; i < NRAND; i++) begin
      rand_word(a);
      rand_word(b);
      case (i % 4)
        0: begin
          instr = rtype(3, 0, 42);
          exp   = {31'd0, $signed(a) < $signed(b)};
        end
        1: begin
          instr = rtype(3, 0, 43);
          exp   = {31'd0, a < b};
        end
        2: begin
          instr = itype(6'h0a, b[15:0]);
          exp   = {31'd0, $signed(a) < $signed({{16{b[15]}}, b[15:0]})};
        end
        default: begin
          instr = itype(6'h0b, b[15:0]);
          exp   = {31'd0, a < {{16{b[15]}}, b[15:0]}};
        end
      endcase
      run_instr(instr, a, b, got);
      check_eq("result", got, exp);
    end

    // error responses
    apb_read(`EX_ADDR_INSTR, got, err);
    check_eq("instr", got, instr);
    apb_write(`EX_ADDR_RESULT, 32'h1234_5678, err);
    check_err("RESULT write", err, 1'b1);
    apb_read(`EX_ADDR_RESULT, got, err);
    check_err("RESULT read", err, 1'b0);
    check_eq("result", got, exp);
    apb_write(12'h006, 32'hffff_ffff, err);
    check_err("misaligned write", err, 1'b1);
    apb_write(12'h104, 32'hffff_ffff, err);
    check_err("unmapped write", err, 1'b1);
    apb_read(12'h104, got, err);
    check_err("unmapped read", err, 1'b1);
    apb_read(12'h004, got, err);
    check_eq("r1", got, a);
    apb_idle();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ex_apb_top.f ====
+incdir+include
hdl/ex_pkg.sv
hdl/alu_decode.sv
hdl/barrel_shifter.sv
hdl/ex.sv
hdl/gpr_file.sv
hdl/ex_apb_top.sv
dv/ex_apb_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f ex_apb_top.f --top-module ex_apb_top_tb -o ex_sim \
  && ./obj_dir/ex_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation did not run"; exit 1; }

cat sim.log
grep -q "^Everything OK$" sim.log && exit 0 || exit 1
